// ==== source/pcie_cfg_settings.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCIe config bridge settings
// Config bus addresses, field widths and BAR defaults
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PCIE_CFG_SETTINGS_SVH
`define PCIE_CFG_SETTINGS_SVH

// Bus widths
`define CFG_ADDR_WIDTH    4
`define CFG_DATA_WIDTH    32
`define BUSDEV_WIDTH      13
`define MSI_ADDR_WIDTH    64
`define RXM_DATA_WIDTH    64

// Config side-band addresses
`define CFG_ADDR_DEVCSR   4'h0     // Device control/status
`define CFG_ADDR_PRMCSR   4'h3     // Primary command/status
`define CFG_ADDR_MSI_LO0  4'h5     // MSI addr 11..0
`define CFG_ADDR_MSI_HI0  4'h6     // MSI addr 43..32
`define CFG_ADDR_MSI_LO1  4'h9     // MSI addr 31..12
`define CFG_ADDR_MSI_HI1  4'hB     // MSI addr 63..44
`define CFG_ADDR_MSI_CTRL 4'hD     // MSI and MSI-X control
`define CFG_ADDR_BUSDEV   4'hF     // Bus/device number and MSI data

// Avalon read masters, only BAR0 and BAR1 fitted by default
`define RXM_NUM_BARS      6
`define RXM_BAR_ENABLE    6'b000011

`define MASTER_ENA_BIT    2        // Bus master enable in command word

`endif

// ==== source/pcie_cfg_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCIe config bridge types
// Vector types of the config and read-return paths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pcie_cfg_settings.svh"

package pcie_cfg_pkg;

   // Config side-band bus from the hard IP
   typedef logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_t;   // Config address
   typedef logic [`CFG_DATA_WIDTH-1:0] cfg_word_t;   // Config data word

   // Decoded config fields
   typedef logic [`BUSDEV_WIDTH-1:0]   busdev_t;     // Bus and device number

   // MSI enable, MSI-X control, primary command and MSI data
   typedef logic [15:0]                cfg_half_t;

   typedef logic [`MSI_ADDR_WIDTH-1:0] msi_addr_t;   // Full 64-bit MSI address

   // MSI view packed as master enable, MSI enable, data, address
   typedef logic [`MSI_ADDR_WIDTH+17:0] msi_intfc_t;

   // Read return from the per-BAR Avalon masters
   typedef logic [`RXM_DATA_WIDTH-1:0] rxm_data_t;   // Read data beat
   typedef logic [`RXM_NUM_BARS-1:0]   bar_mask_t;   // One bit per BAR

endpackage

// ==== source/cfg_bus_sampler.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Config bus sampler
// Syncs reset, captures the config bus after an address change
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cfg_bus_sampler
(
   input  logic                    AvlClk_i,
   input  logic                    Rstn_i,
   input  pcie_cfg_pkg::cfg_addr_t cfg_addr_i,
   input  pcie_cfg_pkg::cfg_word_t cfg_ctl_i,
   output logic                    rst_sync_n_o,
   output pcie_cfg_pkg::cfg_addr_t cap_addr_o,
   output pcie_cfg_pkg::cfg_word_t cap_data_o
);

   import pcie_cfg_pkg::*;

   logic      rst_meta_n;       // First synchronizer stage
   logic      rst_sync_n;
   cfg_addr_t addr_r1;
   cfg_addr_t addr_r2;
   cfg_word_t data_r;
   logic      addr_change;
   logic      addr_change_d;
   logic      addr_strobe;

   // Reset release moved onto the Avalon clock two edges late
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         rst_meta_n <= 1'b0;
         rst_sync_n <= 1'b0;
      end
      else
      begin
         rst_meta_n <= 1'b1;
         rst_sync_n <= rst_meta_n;
      end
   end

   assign rst_sync_n_o = rst_sync_n;

   // Data word follows the bus
   always_ff @(posedge AvlClk_i)
   begin
      data_r <= cfg_ctl_i;
   end

   // Address pipe, change flag and the two-stage strobe delay
   always_ff @(posedge AvlClk_i or negedge rst_sync_n)
   begin
      if (!rst_sync_n)
      begin
         addr_r1       <= '0;
         addr_r2       <= '0;
         addr_change   <= 1'b0;
         addr_change_d <= 1'b0;
         addr_strobe   <= 1'b0;
      end
      else
      begin
         addr_r1       <= cfg_addr_i;
         addr_r2       <= addr_r1;
         addr_change   <= (addr_r1 != addr_r2);   // One cycle pulse per new address
         addr_change_d <= addr_change;
         addr_strobe   <= addr_change_d;          // Bus has settled by now
      end
   end

   // Capture registers load once per address change
   always_ff @(posedge AvlClk_i or negedge rst_sync_n)
   begin
      if (!rst_sync_n)
      begin
         cap_addr_o <= '0;
         cap_data_o <= '0;
      end
      else if (addr_strobe)
      begin
         cap_addr_o <= addr_r1;
         cap_data_o <= data_r;
      end
   end

endmodule

// ==== source/cfg_field_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Config field decoder
// Spreads captured config words into fields and output bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "pcie_cfg_settings.svh"

module cfg_field_decoder
(
   input  logic                     AvlClk_i,
   input  logic                     Rstn_i,
   input  logic                     rst_sync_n_i,
   input  pcie_cfg_pkg::cfg_addr_t  cap_addr_i,
   input  pcie_cfg_pkg::cfg_word_t  cap_data_i,
   output pcie_cfg_pkg::busdev_t    bus_dev_o,
   output pcie_cfg_pkg::cfg_word_t  dev_csr_o,
   output logic                     master_enable_o,
   output pcie_cfg_pkg::cfg_half_t  msi_control_o,
   output pcie_cfg_pkg::cfg_half_t  msix_control_o,
   output pcie_cfg_pkg::msi_intfc_t msi_intfc_o
);

   import pcie_cfg_pkg::*;

   // Decoded fields
   busdev_t   bus_dev;
   cfg_word_t dev_csr;
   cfg_half_t prm_csr;      // Primary command word
   cfg_half_t msi_ena;
   cfg_half_t msix_ctrl;
   cfg_half_t msi_data;
   msi_addr_t msi_addr;

   // Output bank copies not driven straight to a port
   cfg_half_t msi_data_q;
   msi_addr_t msi_addr_q;

   // Fields decode from the held capture word every cycle
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         bus_dev   <= '0;
         dev_csr   <= '0;
         prm_csr   <= '0;
         msi_ena   <= '0;
         msix_ctrl <= '0;
         msi_data  <= '0;
         msi_addr  <= '0;
      end
      else
      begin
         case (cap_addr_i)
            `CFG_ADDR_DEVCSR:  dev_csr <= {16'h0, cap_data_i[31:16]};
            `CFG_ADDR_PRMCSR:  prm_csr <= cap_data_i[23:8];
            `CFG_ADDR_MSI_LO0: msi_addr[11:0]  <= cap_data_i[31:20];
            `CFG_ADDR_MSI_LO1: msi_addr[31:12] <= cap_data_i[31:12];
            `CFG_ADDR_MSI_HI0: msi_addr[43:32] <= cap_data_i[31:20];
            `CFG_ADDR_MSI_HI1: msi_addr[63:44] <= cap_data_i[31:12];
            `CFG_ADDR_MSI_CTRL:
            begin
               msi_ena   <= cap_data_i[15:0];
               msix_ctrl <= cap_data_i[31:16];
            end
            `CFG_ADDR_BUSDEV:
            begin
               bus_dev  <= cap_data_i[12:0];
               msi_data <= cap_data_i[31:16];
            end
            default: ;             // Fields hold on an unused address
         endcase
      end
   end

   // Output bank on the synchronized reset
   always_ff @(posedge AvlClk_i or negedge rst_sync_n_i)
   begin
      if (!rst_sync_n_i)
      begin
         bus_dev_o       <= '0;
         dev_csr_o       <= '0;
         master_enable_o <= 1'b0;
         msi_control_o   <= '0;
         msix_control_o  <= '0;
         msi_data_q      <= '0;
         msi_addr_q      <= '0;
      end
      else
      begin
         bus_dev_o       <= bus_dev;
         dev_csr_o       <= dev_csr;
         master_enable_o <= prm_csr[`MASTER_ENA_BIT];
         msi_control_o   <= msi_ena;
         msix_control_o  <= msix_ctrl;
         msi_data_q      <= msi_data;
         msi_addr_q      <= msi_addr;
      end
   end

   // MSI view for the interrupt logic
   assign msi_intfc_o = {master_enable_o, msi_control_o[0], msi_data_q, msi_addr_q};

endmodule

// ==== source/bar_read_return.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BAR read return
// Merges read data from the per-BAR Avalon masters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "pcie_cfg_settings.svh"

module bar_read_return
#(
   parameter pcie_cfg_pkg::bar_mask_t BAR_ENABLE = `RXM_BAR_ENABLE
)
(
   input  pcie_cfg_pkg::bar_mask_t rxm_read_data_valid_i,
   input  pcie_cfg_pkg::rxm_data_t rxm_read_data_0_i,
   input  pcie_cfg_pkg::rxm_data_t rxm_read_data_1_i,
   input  pcie_cfg_pkg::rxm_data_t rxm_read_data_2_i,
   input  pcie_cfg_pkg::rxm_data_t rxm_read_data_3_i,
   input  pcie_cfg_pkg::rxm_data_t rxm_read_data_4_i,
   input  pcie_cfg_pkg::rxm_data_t rxm_read_data_5_i,
   output logic                    txs_read_data_valid_o,
   output pcie_cfg_pkg::rxm_data_t txs_read_data_o
);

   import pcie_cfg_pkg::*;

   bar_mask_t valid_masked;                 // Valids of fitted BARs only
   rxm_data_t bar_data [`RXM_NUM_BARS];

   assign bar_data[0] = rxm_read_data_0_i;
   assign bar_data[1] = rxm_read_data_1_i;
   assign bar_data[2] = rxm_read_data_2_i;
   assign bar_data[3] = rxm_read_data_3_i;
   assign bar_data[4] = rxm_read_data_4_i;
   assign bar_data[5] = rxm_read_data_5_i;

   // Absent BARs never report data
   assign valid_masked = rxm_read_data_valid_i & BAR_ENABLE;

   assign txs_read_data_valid_o = |valid_masked;

   // Only a single source passes, a collision returns zero
   always_comb
   begin
      txs_read_data_o = '0;
      if ($onehot(valid_masked))
      begin
         for (int i = 0; i < `RXM_NUM_BARS; i++)
         begin
            if (valid_masked[i])
            begin
               txs_read_data_o = bar_data[i];
            end
         end
      end
   end

endmodule

// ==== source/pcie_cfg_bridge.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCIe to Avalon bridge, config side-band and read return
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "pcie_cfg_settings.svh"

module pcie_cfg_bridge
#(
   parameter pcie_cfg_pkg::bar_mask_t BAR_ENABLE = `RXM_BAR_ENABLE   // Fitted BARs
)
(
   input  logic                     AvlClk_i,
   input  logic                     Rstn_i,

   // Config side-band from the hard IP
   input  pcie_cfg_pkg::cfg_addr_t  cfg_addr_i,
   input  pcie_cfg_pkg::cfg_word_t  cfg_ctl_i,

   // Decoded config view
   output pcie_cfg_pkg::busdev_t    bus_dev_o,
   output pcie_cfg_pkg::cfg_word_t  dev_csr_o,
   output logic                     master_enable_o,
   output pcie_cfg_pkg::cfg_half_t  msi_control_o,
   output pcie_cfg_pkg::cfg_half_t  msix_control_o,
   output pcie_cfg_pkg::msi_intfc_t msi_intfc_o,

   // Read return from the Avalon masters
   input  pcie_cfg_pkg::bar_mask_t  rxm_read_data_valid_i,
   input  pcie_cfg_pkg::rxm_data_t  rxm_read_data_0_i,
   input  pcie_cfg_pkg::rxm_data_t  rxm_read_data_1_i,
   input  pcie_cfg_pkg::rxm_data_t  rxm_read_data_2_i,
   input  pcie_cfg_pkg::rxm_data_t  rxm_read_data_3_i,
   input  pcie_cfg_pkg::rxm_data_t  rxm_read_data_4_i,
   input  pcie_cfg_pkg::rxm_data_t  rxm_read_data_5_i,
   output logic                     txs_read_data_valid_o,
   output pcie_cfg_pkg::rxm_data_t  txs_read_data_o
);

   import pcie_cfg_pkg::*;

   logic      rst_sync_n;    // Reset for capture and output bank
   cfg_addr_t cap_addr;
   cfg_word_t cap_data;

   // Stage 1, sample the config bus
   cfg_bus_sampler u_sampler
   (
      .AvlClk_i     (AvlClk_i),
      .Rstn_i       (Rstn_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_ctl_i    (cfg_ctl_i),
      .rst_sync_n_o (rst_sync_n),
      .cap_addr_o   (cap_addr),
      .cap_data_o   (cap_data)
   );

   // Stages 2 and 3, field decode and output bank
   cfg_field_decoder u_decoder
   (
      .AvlClk_i        (AvlClk_i),
      .Rstn_i          (Rstn_i),
      .rst_sync_n_i    (rst_sync_n),
      .cap_addr_i      (cap_addr),
      .cap_data_i      (cap_data),
      .bus_dev_o       (bus_dev_o),
      .dev_csr_o       (dev_csr_o),
      .master_enable_o (master_enable_o),
      .msi_control_o   (msi_control_o),
      .msix_control_o  (msix_control_o),
      .msi_intfc_o     (msi_intfc_o)
   );

   bar_read_return #(
      .BAR_ENABLE (BAR_ENABLE)
   ) u_read_return
   (
      .rxm_read_data_valid_i (rxm_read_data_valid_i),
      .rxm_read_data_0_i     (rxm_read_data_0_i),
      .rxm_read_data_1_i     (rxm_read_data_1_i),
      .rxm_read_data_2_i     (rxm_read_data_2_i),
      .rxm_read_data_3_i     (rxm_read_data_3_i),
      .rxm_read_data_4_i     (rxm_read_data_4_i),
      .rxm_read_data_5_i     (rxm_read_data_5_i),
      .txs_read_data_valid_o (txs_read_data_valid_o),
      .txs_read_data_o       (txs_read_data_o)
   );

endmodule

// ==== bench/tb_clock_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset, 4 ns period, reset 8 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock_gen
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   initial
   begin
      rst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #1 rst_n_o = 1'b1;   // Released clear of the edge
   end

endmodule

// ==== bench/tb_checker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker, models config fields and read return, compares
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "pcie_cfg_settings.svh"

module tb_checker
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  pcie_cfg_pkg::cfg_addr_t  cfg_addr_i,
   input  pcie_cfg_pkg::cfg_word_t  cfg_ctl_i,
   input  pcie_cfg_pkg::busdev_t    bus_dev_i,
   input  pcie_cfg_pkg::cfg_word_t  dev_csr_i,
   input  logic                     master_enable_i,
   input  pcie_cfg_pkg::cfg_half_t  msi_control_i,
   input  pcie_cfg_pkg::cfg_half_t  msix_control_i,
   input  pcie_cfg_pkg::msi_intfc_t msi_intfc_i,
   input  pcie_cfg_pkg::bar_mask_t  rd_valid_i,
   input  logic [383:0]             rd_data_all_i,    // BAR5 down to BAR0
   input  logic                     rr_valid_i,
   input  pcie_cfg_pkg::rxm_data_t  rr_data_i,
   input  logic                     test_done_i,
   input  int                       test_id_i,
   output int                       err_count_o,
   output int                       check_count_o,
   output int                       test_count_o
);

   import pcie_cfg_pkg::*;

   // Reference model of every field
   busdev_t   m_bus_dev;
   cfg_word_t m_dev_csr;
   cfg_half_t m_prm;
   cfg_half_t m_msi_ena;
   cfg_half_t m_msix;
   cfg_half_t m_msi_data;
   msi_addr_t m_msi_addr;

   int        q_due[$];        // Cycle at which a write reaches the outputs
   cfg_addr_t q_addr[$];
   cfg_word_t q_data[$];
   cfg_addr_t last_addr;
   int        cyc;
   int        errors;
   int        checks;
   int        tests;
   int        err_mark;        // Errors at start of the current test
   logic [64:0] rr_exp;

   assign err_count_o   = errors;
   assign check_count_o = checks;
   assign test_count_o  = tests;

   function automatic string test_name(input int id);
      case (id)
         0:       return "reset values";
         1:       return "field decode";
         2:       return "output latency";
         3:       return "repeat and unused address";
         default: return "read return";
      endcase
   endfunction

   // Expected read return, {valid, data}
   function automatic logic [64:0] expect_read(input bar_mask_t vld, input logic [383:0] dall);
      bar_mask_t en;
      int        hits;
      rxm_data_t sel;
      en   = vld & `RXM_BAR_ENABLE;
      hits = 0;
      sel  = '0;
      for (int i = 0; i < `RXM_NUM_BARS; i++)
      begin
         if (en[i])
         begin
            hits++;
            sel = dall[i*64 +: 64];
         end
      end
      return {|en, (hits == 1) ? sel : 64'h0};
   endfunction

   task automatic apply_write(input cfg_addr_t a, input cfg_word_t d);
      case (a)
         `CFG_ADDR_DEVCSR:  m_dev_csr = {16'h0, d[31:16]};
         `CFG_ADDR_PRMCSR:  m_prm = d[23:8];
         `CFG_ADDR_MSI_LO0: m_msi_addr[11:0] = d[31:20];
         `CFG_ADDR_MSI_LO1: m_msi_addr[31:12] = d[31:12];
         `CFG_ADDR_MSI_HI0: m_msi_addr[43:32] = d[31:20];
         `CFG_ADDR_MSI_HI1: m_msi_addr[63:44] = d[31:12];
         `CFG_ADDR_MSI_CTRL:
         begin
            m_msi_ena = d[15:0];
            m_msix    = d[31:16];
         end
         `CFG_ADDR_BUSDEV:
         begin
            m_bus_dev  = d[12:0];
            m_msi_data = d[31:16];
         end
         default: ;   // No field behind this address
      endcase
   endtask

   task automatic check_val(input string name, input logic [81:0] got, input logic [81:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL @ %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Everything runs on the falling edge, where DUT inputs and outputs are settled
   always @(negedge clk_i)
   begin
      cyc++;
      if (!rst_n_i)
      begin
         m_bus_dev  = '0;
         m_dev_csr  = '0;
         m_prm      = '0;
         m_msi_ena  = '0;
         m_msix     = '0;
         m_msi_data = '0;
         m_msi_addr = '0;
         last_addr  = '0;
      end
      else
      begin
         while (q_due.size() > 0 && q_due[0] <= cyc)
         begin
            apply_write(q_addr[0], q_data[0]);
            void'(q_due.pop_front());
            void'(q_addr.pop_front());
            void'(q_data.pop_front());
         end
         check_val("bus_dev", 82'(bus_dev_i), 82'(m_bus_dev));
         check_val("dev_csr", 82'(dev_csr_i), 82'(m_dev_csr));
         check_val("master_enable", 82'(master_enable_i), 82'(m_prm[`MASTER_ENA_BIT]));
         check_val("msi_control", 82'(msi_control_i), 82'(m_msi_ena));
         check_val("msix_control", 82'(msix_control_i), 82'(m_msix));
         check_val("msi_intfc", msi_intfc_i,
                   {m_prm[`MASTER_ENA_BIT], m_msi_ena[0], m_msi_data, m_msi_addr});
         // A new address is sampled at the next rising edge, outputs follow 6 edges on
         if (cfg_addr_i != last_addr)
         begin
            q_due.push_back(cyc + 7);
            q_addr.push_back(cfg_addr_i);
            q_data.push_back(cfg_ctl_i);
            last_addr = cfg_addr_i;
         end
      end
      rr_exp = expect_read(rd_valid_i, rd_data_all_i);
      check_val("read valid", 82'(rr_valid_i), 82'(rr_exp[64]));
      check_val("read data", 82'(rr_data_i), 82'(rr_exp[63:0]));
      if (test_done_i)
      begin
         tests++;
         if (errors == err_mark)
            $display("%s: ok", test_name(test_id_i));
         else
            $display("%s: %0d mismatches", test_name(test_id_i), errors - err_mark);
         err_mark = errors;
      end
   end

endmodule

// ==== bench/tb_pcie_cfg_bridge.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top, drives config writes and read return
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "pcie_cfg_settings.svh"

module tb_pcie_cfg_bridge;

   import pcie_cfg_pkg::*;

   localparam int HOLD        = 12;    // Config bus stable time per write
   localparam int TEST_CYCLES = 12 + 8*HOLD + 3*HOLD + 9*HOLD + 40 + 10;
   localparam int LIMIT       = TEST_CYCLES * 10 + 100;

   logic       clk;
   logic       rst_n;
   cfg_addr_t  cfg_addr;
   cfg_word_t  cfg_ctl;
   busdev_t    bus_dev;
   cfg_word_t  dev_csr;
   logic       master_enable;
   cfg_half_t  msi_control;
   cfg_half_t  msix_control;
   msi_intfc_t msi_intfc;
   bar_mask_t  rd_valid;
   rxm_data_t  rd_data [6];
   logic       rr_valid;
   rxm_data_t  rr_data;
   logic       test_done;
   int         test_id;
   int         err_count;
   int         check_count;
   int         test_count;
   int         cyc_cnt;
   logic [31:0] rng;

   tb_clock_gen clkgen (.clk_o(clk), .rst_n_o(rst_n));

   pcie_cfg_bridge uut
   (
      .AvlClk_i (clk), .Rstn_i (rst_n),
      .cfg_addr_i (cfg_addr), .cfg_ctl_i (cfg_ctl),
      .bus_dev_o (bus_dev), .dev_csr_o (dev_csr),
      .master_enable_o (master_enable), .msi_control_o (msi_control),
      .msix_control_o (msix_control), .msi_intfc_o (msi_intfc),
      .rxm_read_data_valid_i (rd_valid),
      .rxm_read_data_0_i (rd_data[0]), .rxm_read_data_1_i (rd_data[1]),
      .rxm_read_data_2_i (rd_data[2]), .rxm_read_data_3_i (rd_data[3]),
      .rxm_read_data_4_i (rd_data[4]), .rxm_read_data_5_i (rd_data[5]),
      .txs_read_data_valid_o (rr_valid), .txs_read_data_o (rr_data)
   );

   tb_checker chk
   (
      .clk_i (clk), .rst_n_i (rst_n), .cfg_addr_i (cfg_addr), .cfg_ctl_i (cfg_ctl),
      .bus_dev_i (bus_dev), .dev_csr_i (dev_csr), .master_enable_i (master_enable),
      .msi_control_i (msi_control), .msix_control_i (msix_control),
      .msi_intfc_i (msi_intfc), .rd_valid_i (rd_valid),
      .rd_data_all_i ({rd_data[5], rd_data[4], rd_data[3], rd_data[2], rd_data[1], rd_data[0]}),
      .rr_valid_i (rr_valid), .rr_data_i (rr_data),
      .test_done_i (test_done), .test_id_i (test_id),
      .err_count_o (err_count), .check_count_o (check_count), .test_count_o (test_count)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic get_rand(output logic [31:0] r);
      rng = lcg_step(rng);
      r   = rng;
   endtask

   task automatic write_cfg(input cfg_addr_t a);
      logic [31:0] d;
      get_rand(d);
      @(posedge clk);
      #1;
      cfg_addr = a;
      cfg_ctl  = d;
      repeat (HOLD - 1) @(posedge clk);
   endtask

   // One cycle of read return with fresh data on every BAR
   task automatic drive_read(input bar_mask_t v);
      logic [31:0] lo;
      logic [31:0] hi;
      @(posedge clk);
      #1;
      for (int i = 0; i < 6; i++)
      begin
         get_rand(lo);
         get_rand(hi);
         rd_data[i] = {hi, lo};
      end
      rd_valid = v;
   endtask

   task automatic end_test(input int id);
      @(posedge clk);
      #1 test_id = id;
      test_done  = 1'b1;
      @(posedge clk);
      #1 test_done = 1'b0;
   endtask

   always @(posedge clk)
   begin
      cyc_cnt++;
      if (cyc_cnt >= LIMIT)
      begin
         $display("Timeout, run went past %0d cycles", LIMIT);
         $display("test failed");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] r;
      rng       = 32'h9d6a_a56e;
      cfg_addr  = '0;
      cfg_ctl   = '0;
      rd_valid  = '0;
      test_done = 1'b0;
      test_id   = 0;
      for (int i = 0; i < 6; i++)
         rd_data[i] = '0;

      wait (rst_n === 1'b1);
      repeat (10) @(posedge clk);
      end_test(0);

      // Every defined address, never the same one twice in a row
      write_cfg(4'h3);
      write_cfg(4'h5);
      write_cfg(4'h9);
      write_cfg(4'h6);
      write_cfg(4'hB);
      write_cfg(4'hD);
      write_cfg(4'hF);
      write_cfg(4'h0);
      end_test(1);

      write_cfg(4'hD);       // Checker compares every cycle, so early or late shows up
      write_cfg(4'h3);
      write_cfg(4'hF);
      end_test(2);

      write_cfg(4'hF);       // Same address, new data, no capture
      write_cfg(4'h1);
      write_cfg(4'h2);
      write_cfg(4'h4);
      write_cfg(4'h7);
      write_cfg(4'h8);
      write_cfg(4'hA);
      write_cfg(4'hC);
      write_cfg(4'hE);
      end_test(3);

      drive_read(6'b000001);
      drive_read(6'b000010);
      drive_read(6'b000100);
      drive_read(6'b001000);
      drive_read(6'b010000);
      drive_read(6'b100000);
      drive_read(6'b000011);
      drive_read(6'b111100);
      for (int i = 0; i < 20; i++)
      begin
         get_rand(r);
         drive_read(r[13:8]);
      end
      drive_read(6'b000000);
      end_test(4);

      repeat (2) @(posedge clk);
      $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// ==== pcie_cfg_bridge.f ====
+incdir+source
source/pcie_cfg_pkg.sv
source/cfg_bus_sampler.sv
source/cfg_field_decoder.sv
source/bar_read_return.sv
source/pcie_cfg_bridge.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/tb_pcie_cfg_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the config bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_pcie_cfg_bridge \
   -f pcie_cfg_bridge.f \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

if ! grep -q "test passed" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

echo "Simulation finished cleanly"
